//--- hw/vgen_consts.svh
// video generator constants
// small raster timing so a whole frame fits in a short simulation,
// plus field widths and register reset values
`ifndef VGEN_CONSTS_SVH
`define VGEN_CONSTS_SVH

// horizontal timing in pixel clocks
`define H_VISIBLE       32
`define H_FRONT         2
`define H_SYNC          4
`define H_BACK          2
`define H_TOTAL         (`H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK)

// vertical timing in lines
`define V_VISIBLE       6
`define V_FRONT         1
`define V_SYNC          2
`define V_BACK          1
`define V_TOTAL         (`V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK)

`define REG_NUM_W       6                   // register number width
`define PIX_LATENCY     2                   // counter position to pixel out

// register reset values
`define BORDER_RESET    8'h08               // dark grey, shows the generator is alive
`define LINE_LEN_RESET  (`H_VISIBLE / 2)    // one word per two pixels

`endif

//--- hw/vgen_pkg.sv
// video generator types
// data and address words, pixel and count types, the register map
// and the horizontal phase encoding
`include "vgen_consts.svh"
`default_nettype none

package vgen_pkg;

    typedef logic [15:0] word_t;            // data word
    typedef logic [15:0] addr_t;            // vram word address
    typedef logic [7:0]  color_t;           // palette index
    typedef logic [5:0]  hres_t;            // horizontal count
    typedef logic [3:0]  vres_t;            // vertical count

    // video register numbers
    typedef enum logic [`REG_NUM_W-1:0] {
        VID_CTRL     = 6'h00,               // border color in [7:0]
        SCANLINE     = 6'h02,               // read only, current line
        VID_LEFT     = 6'h04,
        VID_RIGHT    = 6'h05,
        PF_GFX_CTRL  = 6'h10,               // colorbase [15:8], blank [7]
        PF_DISP_ADDR = 6'h12,
        PF_LINE_LEN  = 6'h13
    } vgen_reg_e;

    // horizontal line phases
    typedef enum logic [1:0] {
        VISIBLE,
        FRONT,
        SYNC,
        BACK
    } h_phase_e;

endpackage

`default_nettype wire

//--- hw/vgen_ifs.sv
// video generator interfaces
// raster position and events from the timing block, and the
// configuration registers as seen by the pixel path
`default_nettype none

interface video_timing_if import vgen_pkg::*; ();
    hres_t  h_count;
    vres_t  v_count;
    logic   h_visible;
    logic   v_visible;
    logic   end_of_line;                    // last count of a line
    logic   end_of_frame;                   // last count of a frame
    logic   end_of_visible;                 // last visible pixel of the frame
    logic   hsync;
    logic   vsync;
    logic   dv_de;

    modport source (
        output h_count, v_count, h_visible, v_visible,
        output end_of_line, end_of_frame, end_of_visible,
        output hsync, vsync, dv_de
    );

    modport sink (
        input h_count, v_count, h_visible, v_visible,
        input end_of_line, end_of_frame, end_of_visible,
        input hsync, vsync, dv_de
    );
endinterface

interface vgen_cfg_if import vgen_pkg::*; ();
    color_t border_color;
    hres_t  vid_left;                       // first column inside window
    hres_t  vid_right;                      // first column past window
    logic   pf_blank;
    color_t pf_colorbase;
    addr_t  pf_disp_addr;
    word_t  pf_line_len;

    modport regs (
        output border_color, vid_left, vid_right,
        output pf_blank, pf_colorbase, pf_disp_addr, pf_line_len
    );

    modport pixel (
        input border_color, vid_left, vid_right,
        input pf_blank, pf_colorbase, pf_disp_addr, pf_line_len
    );
endinterface

`default_nettype wire

//--- hw/video_timing.sv
// video timing
// free running h/v raster counters with a horizontal phase FSM,
// giving visible flags, active high syncs and line/frame events
`include "vgen_consts.svh"
`default_nettype none

module video_timing import vgen_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    video_timing_if.source  tim
);

    hres_t      h_count;
    vres_t      v_count;
    h_phase_e   h_phase;
    h_phase_e   h_phase_next;
    logic       last_h;                     // last count of the line
    logic       last_v;                     // last line of the frame
    logic       h_visible;
    logic       v_visible;

    assign last_h = (h_count == hres_t'(`H_TOTAL - 1));
    assign last_v = (v_count == vres_t'(`V_TOTAL - 1));

    // each phase ends on its last count
    always_comb begin
        h_phase_next = h_phase;
        case (h_phase)
            VISIBLE: if (h_count == hres_t'(`H_VISIBLE - 1)) h_phase_next = FRONT;
            FRONT:   if (h_count == hres_t'(`H_VISIBLE + `H_FRONT - 1)) h_phase_next = SYNC;
            SYNC: begin
                if (h_count == hres_t'(`H_VISIBLE + `H_FRONT + `H_SYNC - 1)) begin
                    h_phase_next = BACK;
                end
            end
            BACK:    if (last_h) h_phase_next = VISIBLE;
            default: h_phase_next = BACK;
        endcase
    end

    // reset parks on the final count so all outputs idle low,
    // and the first cycle out of reset starts a frame
    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count <= hres_t'(`H_TOTAL - 1);
            v_count <= vres_t'(`V_TOTAL - 1);
            h_phase <= BACK;
        end else begin
            h_phase <= h_phase_next;
            if (last_h) begin
                h_count <= '0;
                v_count <= last_v ? '0 : v_count + 1'b1;
            end else begin
                h_count <= h_count + 1'b1;
            end
        end
    end

    assign h_visible = (h_phase == VISIBLE);
    assign v_visible = (v_count < vres_t'(`V_VISIBLE));

    assign tim.h_count        = h_count;
    assign tim.v_count        = v_count;
    assign tim.h_visible      = h_visible;
    assign tim.v_visible      = v_visible;
    assign tim.end_of_line    = last_h;
    assign tim.end_of_frame   = last_h && last_v;
    assign tim.end_of_visible = (h_count == hres_t'(`H_VISIBLE - 1)) &&
                                (v_count == vres_t'(`V_VISIBLE - 1));
    assign tim.hsync          = (h_phase == SYNC);
    assign tim.vsync          = (v_count >= vres_t'(`V_VISIBLE + `V_FRONT)) &&
                                (v_count < vres_t'(`V_VISIBLE + `V_FRONT + `V_SYNC));
    assign tim.dv_de          = h_visible && v_visible;

    a_h_count_range: assert property (@(posedge clk) disable iff (reset_i)
        h_count < hres_t'(`H_TOTAL));

    // FSM and counter must never drift apart
    a_phase_matches_count: assert property (@(posedge clk) disable iff (reset_i)
        h_visible == (h_count < hres_t'(`H_VISIBLE)));

endmodule

`default_nettype wire

//--- hw/vgen_regs.sv
// video configuration registers
// zero wait state APB slave holding border, window and playfield
// settings, with the end of visible area interrupt pulse
`include "vgen_consts.svh"
`default_nettype none

module vgen_regs import vgen_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   psel_i,
    input  wire logic                   penable_i,
    input  wire logic                   pwrite_i,
    input  wire logic [`REG_NUM_W-1:0]  paddr_i,
    input  wire word_t                  pwdata_i,
    output      word_t                  prdata_o,
    output      logic                   pslverr_o,
    output      logic                   video_intr_o,
    video_timing_if.sink                tim,
    vgen_cfg_if.regs                    cfg
);

    vgen_reg_e  reg_num;
    logic       reg_valid;                  // number maps to a register
    logic       setup;                      // APB setup phase
    logic       wr_access;                  // APB write access phase
    word_t      rd_data;

    color_t     border_color;
    hres_t      vid_left;
    hres_t      vid_right;
    logic       pf_blank;
    color_t     pf_colorbase;
    addr_t      pf_disp_addr;
    word_t      pf_line_len;

    assign reg_num   = vgen_reg_e'(paddr_i);
    assign setup     = psel_i && !penable_i;
    assign wr_access = psel_i && penable_i && pwrite_i;

    // read mux and decode
    always_comb begin
        reg_valid = 1'b1;
        rd_data   = '0;
        case (reg_num)
            VID_CTRL:     rd_data = {8'h00, border_color};
            SCANLINE:     rd_data = word_t'(tim.v_count);
            VID_LEFT:     rd_data = word_t'(vid_left);
            VID_RIGHT:    rd_data = word_t'(vid_right);
            PF_GFX_CTRL:  rd_data = {pf_colorbase, pf_blank, 7'b0};
            PF_DISP_ADDR: rd_data = pf_disp_addr;
            PF_LINE_LEN:  rd_data = pf_line_len;
            default:      reg_valid = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            border_color <= `BORDER_RESET;
            vid_left     <= '0;
            vid_right    <= hres_t'(`H_VISIBLE);
            pf_blank     <= 1'b0;
            pf_colorbase <= '0;
            pf_disp_addr <= '0;
            pf_line_len  <= word_t'(`LINE_LEN_RESET);
            pslverr_o    <= 1'b0;
            video_intr_o <= 1'b0;
        end else begin
            video_intr_o <= tim.end_of_visible;     // one pulse per frame
            // error decided in setup, shown during access
            pslverr_o    <= setup && (!reg_valid || (pwrite_i && reg_num == SCANLINE));

            if (wr_access) begin
                case (reg_num)
                    VID_CTRL:     border_color <= pwdata_i[7:0];
                    VID_LEFT:     vid_left     <= hres_t'(pwdata_i);
                    VID_RIGHT:    vid_right    <= hres_t'(pwdata_i);
                    PF_GFX_CTRL: begin
                        pf_colorbase <= pwdata_i[15:8];
                        pf_blank     <= pwdata_i[7];
                    end
                    PF_DISP_ADDR: pf_disp_addr <= pwdata_i;
                    PF_LINE_LEN:  pf_line_len  <= pwdata_i;
                    default: ;                      // scanline and holes ignored
                endcase
            end
        end
    end

    // read data sampled in setup so it is stable through access
    always_ff @(posedge clk) begin
        if (setup) begin
            prdata_o <= rd_data;
        end
    end

    assign cfg.border_color = border_color;
    assign cfg.vid_left     = vid_left;
    assign cfg.vid_right    = vid_right;
    assign cfg.pf_blank     = pf_blank;
    assign cfg.pf_colorbase = pf_colorbase;
    assign cfg.pf_disp_addr = pf_disp_addr;
    assign cfg.pf_line_len  = pf_line_len;

    a_penable_needs_psel: assert property (@(posedge clk) disable iff (reset_i)
        penable_i |-> psel_i);

    // zero wait states, every access phase follows exactly one setup
    a_access_after_setup: assert property (@(posedge clk) disable iff (reset_i)
        (psel_i && penable_i) |-> $past(psel_i && !penable_i));

endmodule

`default_nettype wire

//--- hw/bitmap_fetch.sv
// bitmap playfield fetch
// reads one vram word per two visible columns, splits it into two
// 8-bit pixels and applies colorbase, window and border
`include "vgen_consts.svh"
`default_nettype none

module bitmap_fetch import vgen_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    video_timing_if.sink    tim,
    vgen_cfg_if.pixel       cfg,
    output      logic       vram_sel_o,
    output      addr_t      vram_addr_o,
    input  wire word_t      vram_data_i,
    output      color_t     color_index_o
);

    addr_t      line_addr;                  // first word of current line
    word_t      line_len;                   // frame copy of pf_line_len
    logic       in_window;
    logic       fetch;
    logic       pix_vis_d1;                 // stage 1 column is visible
    logic       odd_d1;                     // stage 1 column is odd
    logic       show_d1;                    // stage 1 shows bitmap, not border
    word_t      word_q;                     // held word for the odd column
    color_t     pix_byte;

    assign in_window = (tim.h_count >= cfg.vid_left) && (tim.h_count < cfg.vid_right);

    // one read at each even visible column
    assign fetch       = tim.h_visible && tim.v_visible && !tim.h_count[0] && !cfg.pf_blank;
    assign vram_sel_o  = fetch;
    assign vram_addr_o = line_addr + addr_t'(tim.h_count[5:1]);

    // address and length are taken once per frame, step after each
    // visible line
    always_ff @(posedge clk) begin
        if (tim.end_of_frame) begin
            line_addr <= cfg.pf_disp_addr;
            line_len  <= cfg.pf_line_len;
        end else if (tim.end_of_line && tim.v_visible) begin
            line_addr <= line_addr + line_len;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pix_vis_d1 <= 1'b0;
            odd_d1     <= 1'b0;
            show_d1    <= 1'b0;
        end else begin
            pix_vis_d1 <= tim.dv_de;
            odd_d1     <= tim.h_count[0];
            show_d1    <= in_window && !cfg.pf_blank;
        end
    end

    // vram word arrives while its even column is in stage 1
    always_ff @(posedge clk) begin
        if (!odd_d1) begin
            word_q <= vram_data_i;
        end
    end

    assign pix_byte = odd_d1 ? word_q[7:0] : vram_data_i[15:8];     // high byte first

    always_ff @(posedge clk) begin
        if (reset_i) begin
            color_index_o <= '0;
        end else if (!pix_vis_d1) begin
            color_index_o <= '0;
        end else if (!show_d1) begin
            color_index_o <= cfg.border_color;
        end else begin
            color_index_o <= pix_byte ^ cfg.pf_colorbase;
        end
    end

    // reads only land on displayed pixels
    a_fetch_in_display: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o |-> (tim.h_count < hres_t'(`H_VISIBLE)) &&
                       (tim.v_count < vres_t'(`V_VISIBLE)));

endmodule

`default_nettype wire

//--- hw/video_gen.sv
// video generator top
// timing, registers and bitmap fetch on plain ports, with syncs
// and display enable delayed to line up with the pixel output
`include "vgen_consts.svh"
`default_nettype none

module video_gen import vgen_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    // APB register port
    input  wire logic                   psel_i,
    input  wire logic                   penable_i,
    input  wire logic                   pwrite_i,
    input  wire logic [`REG_NUM_W-1:0]  paddr_i,
    input  wire word_t                  pwdata_i,
    output      word_t                  prdata_o,
    output      logic                   pslverr_o,
    output      logic                   video_intr_o,
    // video memory
    output      logic                   vram_sel_o,
    output      addr_t                  vram_addr_o,
    input  wire word_t                  vram_data_i,
    // video out
    output      color_t                 color_index_o,
    output      logic                   hsync_o,
    output      logic                   vsync_o,
    output      logic                   dv_de_o
);

    video_timing_if tim_if();
    vgen_cfg_if     cfg_if();

    logic [2:0]     sync_d [`PIX_LATENCY];  // {hsync, vsync, dv_de} per stage

    video_timing u_timing (
        .clk        (clk),
        .reset_i    (reset_i),
        .tim        (tim_if.source)
    );

    vgen_regs u_regs (
        .clk            (clk),
        .reset_i        (reset_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .pslverr_o      (pslverr_o),
        .video_intr_o   (video_intr_o),
        .tim            (tim_if.sink),
        .cfg            (cfg_if.regs)
    );

    bitmap_fetch u_fetch (
        .clk            (clk),
        .reset_i        (reset_i),
        .tim            (tim_if.sink),
        .cfg            (cfg_if.pixel),
        .vram_sel_o     (vram_sel_o),
        .vram_addr_o    (vram_addr_o),
        .vram_data_i    (vram_data_i),
        .color_index_o  (color_index_o)
    );

    // match the pixel pipeline depth
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `PIX_LATENCY; i++) begin
                sync_d[i] <= '0;
            end
        end else begin
            sync_d[0] <= {tim_if.hsync, tim_if.vsync, tim_if.dv_de};
            for (int i = 1; i < `PIX_LATENCY; i++) begin
                sync_d[i] <= sync_d[i-1];
            end
        end
    end

    assign {hsync_o, vsync_o, dv_de_o} = sync_d[`PIX_LATENCY-1];

endmodule

`default_nettype wire

//--- tb/vgen_checker.sv
// video output checker
// follows dv_de_o, hsync_o and vsync_o through one armed frame, predicts
// each pixel from the expected configuration and counts the errors
`include "vgen_consts.svh"
`default_nettype none

module vgen_checker import vgen_pkg::*; (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire color_t         color_index_i,
    input  wire logic           dv_de_i,
    input  wire logic           hsync_i,
    input  wire logic           vsync_i,
    input  wire logic           video_intr_i,
    input  wire logic           start_i,            // check the coming frame
    input  wire logic [95:0]    test_name_i,
    input  wire color_t         border_i,
    input  wire color_t         colorbase_i,
    input  wire logic           blank_i,
    input  wire addr_t          disp_addr_i,
    input  wire word_t          line_len_i,
    input  wire hres_t          left_i,
    input  wire hres_t          right_i,
    output      logic           done_o,
    output      int             error_count_o
);

    logic   active;
    logic   dv_q;
    logic   vsync_q;
    int     x_count;
    int     y_count;
    int     intr_count;
    int     hsync_cycles;
    color_t expected;

    // two pixels per vram word, high byte on the even column
    function automatic color_t expected_pixel(int x, int y);
        addr_t addr;
        word_t data;
        if (blank_i || x < 32'(left_i) || x >= 32'(right_i)) begin
            return border_i;
        end
        addr = disp_addr_i + 16'(y) * line_len_i + 16'(x / 2);
        data = addr ^ 16'h5a5a;
        return ((x % 2 == 0) ? data[15:8] : data[7:0]) ^ colorbase_i;
    endfunction

    always @(posedge clk) begin
        done_o = 1'b0;
        if (reset_i) begin
            active        = 1'b0;
            error_count_o = 0;
        end else if (start_i) begin
            active       = 1'b1;
            x_count      = 0;
            y_count      = 0;
            intr_count   = 0;
            hsync_cycles = 0;
        end else if (active) begin
            if (dv_de_i) begin
                expected = expected_pixel(x_count, y_count);
                if (color_index_i !== expected) begin
                    $display("MISMATCH %0s pixel x=%0d y=%0d: expected %02h actual %02h",
                             test_name_i, x_count, y_count, expected, color_index_i);
                    error_count_o++;
                end
                x_count++;
            end
            if (dv_q && !dv_de_i) begin                 // visible line just ended
                if (x_count != `H_VISIBLE) begin
                    $display("MISMATCH %0s pixels in line %0d: expected %0d actual %0d",
                             test_name_i, y_count, `H_VISIBLE, x_count);
                    error_count_o++;
                end
                x_count = 0;
                y_count++;
            end
            if (video_intr_i) begin
                intr_count++;
            end
            if (hsync_i) begin
                hsync_cycles++;
            end
            if (vsync_i && !vsync_q) begin              // next vsync closes the frame
                if (y_count != `V_VISIBLE) begin
                    $display("MISMATCH %0s visible lines: expected %0d actual %0d",
                             test_name_i, `V_VISIBLE, y_count);
                    error_count_o++;
                end
                if (intr_count != 1) begin
                    $display("MISMATCH %0s interrupts per frame: expected 1 actual %0d",
                             test_name_i, intr_count);
                    error_count_o++;
                end
                if (hsync_cycles != `V_TOTAL * `H_SYNC) begin
                    $display("MISMATCH %0s hsync cycles per frame: expected %0d actual %0d",
                             test_name_i, `V_TOTAL * `H_SYNC, hsync_cycles);
                    error_count_o++;
                end
                active = 1'b0;
                done_o = 1'b1;
            end
        end
        dv_q    = dv_de_i;
        vsync_q = vsync_i;
    end

endmodule

`default_nettype wire

//--- tb/tb_video_gen.sv
// video generator testbench
// programs the registers over APB for each table row, reads them back
// and lets the checker verify the next full frame
`include "vgen_consts.svh"
`default_nettype none

module tb_video_gen import vgen_pkg::*; ();

    localparam int NUM_TESTS  = 5;
    localparam int WAIT_LIMIT = 2 * `H_TOTAL * `V_TOTAL;   // two frames

    typedef logic [8*12-1:0] name_t;                        // up to 12 characters

    typedef struct packed {
        name_t  name;
        color_t border;
        color_t colorbase;
        logic   blank;
        logic   rand_addr;                                  // draw display address at random
        addr_t  disp_addr;
        word_t  line_len;
        hres_t  left;
        hres_t  right;
    } test_row_t;

    logic                   clk;
    logic                   reset_i;
    logic                   psel_i;
    logic                   penable_i;
    logic                   pwrite_i;
    logic [`REG_NUM_W-1:0]  paddr_i;
    word_t                  pwdata_i;
    word_t                  prdata_o;
    logic                   pslverr_o;
    logic                   video_intr_o;
    logic                   vram_sel_o;
    addr_t                  vram_addr_o;
    word_t                  vram_data_i;
    color_t                 color_index_o;
    logic                   hsync_o;
    logic                   vsync_o;
    logic                   dv_de_o;

    test_row_t  tests [NUM_TESTS];
    test_row_t  exp;                                        // configuration now in the DUT
    logic       check_start;
    logic       check_done;
    int         check_errors;
    int         test_errors;
    int         total_errors;
    int         tests_run;
    int         tests_failed;
    logic       aborted;

    video_gen dut (.*);

    vgen_checker chk (
        .clk            (clk),
        .reset_i        (reset_i),
        .color_index_i  (color_index_o),
        .dv_de_i        (dv_de_o),
        .hsync_i        (hsync_o),
        .vsync_i        (vsync_o),
        .video_intr_i   (video_intr_o),
        .start_i        (check_start),
        .test_name_i    (exp.name),
        .border_i       (exp.border),
        .colorbase_i    (exp.colorbase),
        .blank_i        (exp.blank),
        .disp_addr_i    (exp.disp_addr),
        .line_len_i     (exp.line_len),
        .left_i         (exp.left),
        .right_i        (exp.right),
        .done_o         (check_done),
        .error_count_o  (check_errors)
    );

    always #50 clk = ~clk;

    // vram model, word is its address xor a constant, one cycle latency
    always @(posedge clk) begin
        if (vram_sel_o) begin
            vram_data_i <= vram_addr_o ^ 16'h5a5a;
        end
    end

    // one zero wait state APB transfer, response sampled mid access phase
    task automatic apb_access(input logic write, input logic [`REG_NUM_W-1:0] addr,
                              input word_t wdata, output word_t rdata, output logic err);
        @(posedge clk);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= write;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        @(posedge clk);
        penable_i <= 1'b1;
        @(negedge clk);
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic write_reg(input vgen_reg_e num, input word_t data);
        word_t unused;
        logic  err;
        apb_access(1'b1, num, data, unused, err);
        if (err) begin
            $display("%0s: write to register %02h was refused with pslverr", exp.name, num);
            test_errors++;
        end
    endtask

    task automatic expect_reg(input vgen_reg_e num, input word_t value);
        word_t data;
        logic  err;
        apb_access(1'b0, num, 16'h0000, data, err);
        if (err || data !== value) begin
            $display("MISMATCH %0s reg %02h: expected %04h actual %04h%0s", exp.name, num,
                     value, data, err ? " with pslverr" : "");
            test_errors++;
        end
    endtask

    task automatic expect_slverr(input logic write, input logic [`REG_NUM_W-1:0] addr);
        word_t data;
        logic  err;
        apb_access(write, addr, 16'hbeef, data, err);
        if (!err) begin
            $display("%0s: access to register %02h did not raise pslverr", exp.name, addr);
            test_errors++;
        end
    endtask

    task automatic write_config();
        write_reg(VID_CTRL, {8'h00, exp.border});
        write_reg(VID_LEFT, word_t'(exp.left));
        write_reg(VID_RIGHT, word_t'(exp.right));
        write_reg(PF_GFX_CTRL, {exp.colorbase, exp.blank, 7'h00});
        write_reg(PF_DISP_ADDR, exp.disp_addr);
        write_reg(PF_LINE_LEN, exp.line_len);
    endtask

    task automatic check_config();
        word_t data;
        logic  err;
        expect_reg(VID_CTRL, {8'h00, exp.border});
        expect_reg(VID_LEFT, word_t'(exp.left));
        expect_reg(VID_RIGHT, word_t'(exp.right));
        expect_reg(PF_GFX_CTRL, {exp.colorbase, exp.blank, 7'h00});
        expect_reg(PF_DISP_ADDR, exp.disp_addr);
        expect_reg(PF_LINE_LEN, exp.line_len);
        apb_access(1'b0, SCANLINE, 16'h0000, data, err);
        if (err || data >= 16'(`V_TOTAL)) begin
            $display("MISMATCH %0s scanline: expected below %04h actual %04h", exp.name,
                     16'(`V_TOTAL), data);
            test_errors++;
        end
    endtask

    // new settings are live from the frame after the next vsync
    task automatic check_next_frame();
        logic prev;
        logic seen;
        int   n;
        seen = 1'b0;
        @(negedge clk);
        prev = vsync_o;
        for (n = 0; n < WAIT_LIMIT && !seen; n++) begin
            @(negedge clk);
            seen = vsync_o && !prev;
            prev = vsync_o;
        end
        if (!seen) begin
            $display("timeout: vsync_o did not rise within %0d cycles", WAIT_LIMIT);
            aborted = 1'b1;
        end else begin
            @(posedge clk);
            check_start <= 1'b1;
            @(posedge clk);
            check_start <= 1'b0;
            seen = 1'b0;
            for (n = 0; n < WAIT_LIMIT && !seen; n++) begin
                @(negedge clk);
                seen = check_done;
            end
            if (!seen) begin
                $display("timeout: checker did not finish a frame within %0d cycles",
                         WAIT_LIMIT);
                aborted = 1'b1;
            end
        end
    endtask

    task automatic finish_test();
        if (aborted) begin
            test_errors++;
        end
        $display("test %0s: %0s, %0d errors", exp.name, (test_errors == 0) ? "ok" : "FAILED",
                 test_errors);
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        int          base;
        logic [13:0] idle_outs;
        clk          = 1'b0;
        reset_i      = 1'b1;
        psel_i       = 1'b0;
        penable_i    = 1'b0;
        pwrite_i     = 1'b0;
        paddr_i      = '0;
        pwdata_i     = '0;
        vram_data_i  = '0;
        check_start  = 1'b0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        exp = '{name_t'("reset"), `BORDER_RESET, 8'h00, 1'b0, 1'b0, 16'h0000,
                16'(`LINE_LEN_RESET), 6'd0, 6'(`H_VISIBLE)};

        // name, border, colorbase, blank, random address, address, line length, left, right
        tests[0] = '{name_t'("fixed_addr"), 8'h08, 8'h00, 1'b0, 1'b0,
                     16'h0100, 16'd16, 6'd0, 6'd32};
        tests[1] = '{name_t'("rand_addr"), 8'h11, 8'h3c, 1'b0, 1'b1,
                     16'h0000, 16'd23, 6'd0, 6'd32};
        tests[2] = '{name_t'("wide_lines"), 8'h22, 8'ha5, 1'b0, 1'b1,
                     16'h0000, 16'd40, 6'd0, 6'd32};
        tests[3] = '{name_t'("blank"), 8'h5e, 8'hff, 1'b1, 1'b1,
                     16'h0000, 16'd16, 6'd0, 6'd32};
        tests[4] = '{name_t'("window"), 8'h77, 8'h0f, 1'b0, 1'b1,
                     16'h0000, 16'd20, 6'd5, 6'd27};

        void'($urandom(32'hccd6));
        repeat (7) @(posedge clk);
        @(negedge clk);
        idle_outs = {hsync_o, vsync_o, dv_de_o, video_intr_o, vram_sel_o, pslverr_o,
                     color_index_o};
        if (idle_outs !== '0) begin
            $display("MISMATCH reset outputs: expected %04h actual %04h", 14'h0, idle_outs);
            test_errors++;
        end
        @(posedge clk);
        reset_i <= 1'b0;
        check_config();
        finish_test();

        for (int t = 0; t < NUM_TESTS && !aborted; t++) begin
            exp = tests[t];
            if (exp.rand_addr) begin
                exp.disp_addr = addr_t'($urandom);
            end
            base = check_errors;
            write_config();
            check_config();
            check_next_frame();
            test_errors += check_errors - base;
            finish_test();
        end

        if (!aborted) begin
            exp.name = name_t'("bad_access");
            expect_slverr(1'b1, 6'h3f);
            expect_slverr(1'b1, SCANLINE);
            expect_slverr(1'b0, 6'h21);
            check_config();                                 // nothing may have changed
            finish_test();
        end

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors);
        if (!aborted && total_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hw
hw/vgen_pkg.sv
hw/vgen_ifs.sv
hw/video_timing.sv
hw/vgen_regs.sv
hw/bitmap_fetch.sv
hw/video_gen.sv
tb/vgen_checker.sv
tb/tb_video_gen.sv

//--- Makefile
# Verilator build and run of the video generator testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_video_gen -f vlog.f \
		-Mdir obj_dir -o tb_video_gen
	./obj_dir/tb_video_gen | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "test FAILED"; exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG) || \
		{ echo "no result in $(LOG)"; exit 1; }
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)
